//--- Bender.yml
package:
  name: stair_array

sources:
  - verilog/mx_num_pkg.sv
  - verilog/stair_geom_pkg.sv
  - verilog/run_fsm.sv
  - verilog/feed_counter.sv
  - verilog/operand_skewer.sv
  - verilog/pair_pe.sv
  - verilog/stair_grid.sv
  - verilog/stair_top.sv
  - target: test
    files:
      - verification/stair_checker.sv
      - verification/tb_stair.sv

//--- all.f
verilog/mx_num_pkg.sv
verilog/stair_geom_pkg.sv
verilog/run_fsm.sv
verilog/feed_counter.sv
verilog/operand_skewer.sv
verilog/pair_pe.sv
verilog/stair_grid.sv
verilog/stair_top.sv
verification/stair_checker.sv
verification/tb_stair.sv

//--- verification/stair_checker.sv
`timescale 1ns/1ps

module stair_checker
	import mx_num_pkg::*;
	import stair_geom_pkg::*;
#(
	parameter int NUM_TESTS = 1
) (
	input  logic          CLK,
	input  logic          RSTN,
	input  logic          enable,
	input  op_e           operation,
	input  block_t        block,
	input  pair_results_t results,
	input  logic          result_valid,
	output int            value_errs,
	output int            timing_errs,
	output int            timeout_errs,
	output int            checks_done,
	output logic          timed_out
);

	localparam int RISE_EDGES  = FEED_LAST + 2; // Edges from enable to result_valid
	localparam int CYCLE_LIMIT = NUM_TESTS * (FEED_LAST + 8) + 50;

	string test_name = "reset";
	logic  prev_en;
	logic  prev_rv;
	logic  tracking;
	int    edges;
	int    cycles;

	// Pairs by row, highest column first
	function automatic pair_results_t expected_results(input block_t blk, input op_e op);
		pair_results_t res;
		longint acc;
		int p;
		res = '0;
		p = 0;
		for (int r = 0; r < NUM_GROUPS - 1; r++) begin
			for (int c = NUM_GROUPS - 1; c > r; c--) begin
				acc = 0;
				for (int k = 0; k < GROUP_LEN; k++) begin
					case (op)
						OP_MUL:  acc += longint'(blk[r][k]) * longint'(blk[c][k]);
						OP_ADD:  acc += longint'(blk[r][k]) + longint'(blk[c][k]);
						default: acc += longint'(blk[r][k]) - longint'(blk[c][k]);
					endcase
				end
				res[p] = elem_t'(acc[ELEM_W-1:0]); // Two's-complement wrap
				p++;
			end
		end
		return res;
	endfunction

	task automatic compare_results();
		pair_results_t exp;
		int p;
		exp = expected_results(block, operation);
		p = 0;
		for (int r = 0; r < NUM_GROUPS - 1; r++) begin
			for (int c = NUM_GROUPS - 1; c > r; c--) begin
				if (results[p] !== exp[p]) begin
					$display("mismatch %s pair (%0d,%0d): expected %0d, actual %0d",
						test_name, r, c, exp[p], results[p]);
					value_errs++;
				end
				p++;
			end
		end
		checks_done++;
	endtask

	initial begin
		value_errs   = 0;
		timing_errs  = 0;
		timeout_errs = 0;
		checks_done  = 0;
		timed_out    = 1'b0;
		cycles       = 0;
	end

	always @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			prev_en  = 1'b0;
			prev_rv  = 1'b0;
			tracking = 1'b0;
			edges    = 0;
		end else begin
			if (enable && !prev_en) begin
				tracking = 1'b1; // Enable first sampled high
				edges    = 0;
			end else if (enable && tracking) begin
				edges++;
			end else if (!enable) begin
				tracking = 1'b0;
			end
			if (tracking && edges < RISE_EDGES && result_valid) begin
				$display("timing error in %s: result_valid high %0d edges after enable",
					test_name, edges);
				timing_errs++;
			end else if (tracking && edges >= RISE_EDGES && !result_valid) begin
				$display("timing error in %s: result_valid low %0d edges after enable",
					test_name, edges);
				timing_errs++;
			end
			if (!enable && !prev_en && result_valid) begin
				$display("timing error in %s: result_valid high while enable is low",
					test_name);
				timing_errs++;
			end
			if (result_valid && !prev_rv) begin
				compare_results();
			end
			prev_en = enable;
			prev_rv = result_valid;
		end
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles > CYCLE_LIMIT && !timed_out) begin
			$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			timeout_errs++;
			timed_out = 1'b1;
		end
	end

endmodule

//--- verification/tb_stair.sv
`timescale 1ns/1ps

module tb_stair
	import mx_num_pkg::*;
	import stair_geom_pkg::*;
();

	localparam int NUM_TESTS = 16; // Abort and its restart count as two

	logic          CLK;
	logic          RSTN;
	logic          enable;
	op_e           operation;
	block_t        block;
	pair_results_t results;
	logic          result_valid;
	int            value_errs;
	int            timing_errs;
	int            timeout_errs;
	int            checks_done;
	logic          timed_out;
	int            runs_done;
	logic [15:0]   lfsr_state;

	stair_top u_dut (
		.CLK         (CLK),
		.RSTN        (RSTN),
		.enable      (enable),
		.operation   (operation),
		.block       (block),
		.results     (results),
		.result_valid(result_valid)
	);

	stair_checker #(.NUM_TESTS(NUM_TESTS)) u_chk (
		.CLK         (CLK),
		.RSTN        (RSTN),
		.enable      (enable),
		.operation   (operation),
		.block       (block),
		.results     (results),
		.result_valid(result_valid),
		.value_errs  (value_errs),
		.timing_errs (timing_errs),
		.timeout_errs(timeout_errs),
		.checks_done (checks_done),
		.timed_out   (timed_out)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	task automatic draw_elem(output elem_t v);
		for (int i = 0; i < ELEM_W; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	task automatic random_block(output block_t b);
		elem_t e;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int k = 0; k < GROUP_LEN; k++) begin
				draw_elem(e);
				b[g][k] = e;
			end
		end
	endtask

	function automatic block_t const_block(input elem_t v);
		block_t b;
		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int k = 0; k < GROUP_LEN; k++) begin
				b[g][k] = v;
			end
		end
		return b;
	endfunction

	task automatic run_block(input string name, input op_e op, input block_t blk);
		@(posedge CLK);
		u_chk.test_name = name;
		block     <= blk;
		operation <= op;
		enable    <= 1'b1;
		@(posedge CLK);
		while (!result_valid) begin
			@(posedge CLK);
		end
		@(posedge CLK); // One more cycle in DONE
		enable <= 1'b0;
		repeat (2) @(posedge CLK);
		runs_done++;
	endtask

	// Drops enable in the middle of feeding
	task automatic abort_run(input op_e op, input block_t blk);
		@(posedge CLK);
		u_chk.test_name = "abort";
		block     <= blk;
		operation <= op;
		enable    <= 1'b1;
		repeat (6) @(posedge CLK);
		enable <= 1'b0;
		repeat (2) @(posedge CLK);
	endtask

	task automatic print_verdict();
		int unchecked;
		int total;
		unchecked = runs_done - checks_done;
		total = value_errs + timing_errs + timeout_errs + unchecked;
		$display("errors: mismatch %0d, timing %0d, timeout %0d, unchecked runs %0d",
			value_errs, timing_errs, timeout_errs, unchecked);
		if (total == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	initial begin
		wait (timed_out);
		print_verdict();
	end

	initial begin
		block_t blk;
		RSTN       = 1'b0;
		enable     = 1'b0;
		operation  = OP_MUL;
		block      = '0;
		runs_done  = 0;
		lfsr_state = 16'd98;
		repeat (5) @(posedge CLK);
		RSTN <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			random_block(blk);
			run_block($sformatf("mul_random_%0d", i), OP_MUL, blk);
		end
		for (int i = 0; i < 2; i++) begin
			random_block(blk);
			run_block($sformatf("add_random_%0d", i), OP_ADD, blk);
			random_block(blk);
			run_block($sformatf("sub_random_%0d", i), OP_SUB, blk);
		end
		for (int o = 0; o < 3; o++) begin
			run_block($sformatf("min_op%0d", o), op_e'(o), const_block(16'sh8000));
			run_block($sformatf("max_op%0d", o), op_e'(o), const_block(16'sh7FFF));
		end
		random_block(blk);
		abort_run(OP_MUL, blk);
		random_block(blk);
		run_block("after_abort", OP_SUB, blk);
		print_verdict();
	end

endmodule

//--- verilog/feed_counter.sv
`timescale 1ns/1ps

module feed_counter
	import stair_geom_pkg::*;
(
	input  logic   CLK,
	input  logic   RSTN,
	input  logic   run,
	output count_t count,
	output logic   last
);

	assign last = (count == FEED_LAST);

	always_ff @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			count <= '0;
		end else if (run && !last) begin
			count <= count + 1'b1;
		end else begin
			count <= '0; // Idle, done or final cycle
		end
	end

	a_count_range: assert property (@(posedge CLK) disable iff (!RSTN)
		count <= FEED_LAST);

	// The sequencer leaves FEED right after the final count
	a_last_ends_run: assert property (@(posedge CLK) disable iff (!RSTN)
		last |=> !run);

endmodule

//--- verilog/mx_num_pkg.sv
package mx_num_pkg;

	localparam int ELEM_W = 16; // Element and result width

	// One signed operand element or wrapped result
	typedef logic signed [ELEM_W-1:0] elem_t;

	// Operation applied between a data and a weight element
	typedef enum logic [1:0] {
		OP_MUL = 2'd0, // Accumulate d * w
		OP_ADD = 2'd1, // Accumulate d + w
		OP_SUB = 2'd2  // Accumulate d - w
	} op_e;

endpackage

//--- verilog/operand_skewer.sv
`timescale 1ns/1ps

module operand_skewer
	import mx_num_pkg::*;
	import stair_geom_pkg::*;
(
	input  logic   CLK,
	input  logic   RSTN,
	input  logic   run,
	input  count_t count,
	input  block_t block,
	output lanes_t lanes
);

	lanes_t lanes_nxt;

	// Element count - offset of the group, zero outside the group
	function automatic elem_t pick(input group_t grp, input count_t cnt, input int offset);
		int idx;
		idx = int'(cnt) - offset;
		if (idx >= 0 && idx < GROUP_LEN) begin
			return grp[idx];
		end
		return '0;
	endfunction

	always_comb begin
		lanes_nxt = '0;
		if (run) begin
			for (int r = 0; r < NUM_GROUPS - 1; r++) begin
				lanes_nxt.data[r] = pick(block[r], count, r);
			end
			for (int c = 1; c < NUM_GROUPS; c++) begin
				lanes_nxt.weight[c] = pick(block[c], count, NUM_GROUPS - 1 - c);
			end
		end
	end

	always_ff @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			lanes <= '0;
		end else begin
			lanes <= lanes_nxt;
		end
	end

endmodule

//--- verilog/pair_pe.sv
`timescale 1ns/1ps

module pair_pe
	import mx_num_pkg::*;
(
	input  logic  CLK,
	input  logic  RSTN,
	input  logic  clear,
	input  op_e   operation,
	input  elem_t d_in,
	input  elem_t w_in,
	output elem_t d_out,
	output elem_t w_out,
	output elem_t result
);

	elem_t term;

	always_comb begin
		case (operation)
			OP_MUL:  term = d_in * w_in; // Low half of the product
			OP_ADD:  term = d_in + w_in;
			OP_SUB:  term = d_in - w_in;
			default: term = '0;
		endcase
	end

	// Forwarding stage, flushed while idle
	always_ff @(posedge CLK) begin
		if (clear) begin
			d_out <= '0;
			w_out <= '0;
		end else begin
			d_out <= d_in;
			w_out <= w_in;
		end
	end

	always_ff @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			result <= '0;
		end else if (clear) begin
			result <= '0;
		end else begin
			result <= result + term; // Wraps at 16 bits
		end
	end

	a_op_legal: assert property (@(posedge CLK) disable iff (!RSTN)
		!clear |-> operation inside {OP_MUL, OP_ADD, OP_SUB});

endmodule

//--- verilog/run_fsm.sv
`timescale 1ns/1ps

module run_fsm (
	input  logic CLK,
	input  logic RSTN,
	input  logic enable,
	input  logic last,
	output logic run,
	output logic clear,
	output logic result_valid
);

	typedef enum logic [1:0] {
		IDLE,
		FEED,
		DONE
	} run_state_e;

	run_state_e state;
	run_state_e state_nxt;

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (enable) begin
					state_nxt = FEED;
				end
			end
			FEED: begin
				if (!enable) begin
					state_nxt = IDLE; // Run aborted
				end else if (last) begin
					state_nxt = DONE;
				end
			end
			DONE: begin
				if (!enable) begin
					state_nxt = IDLE;
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	// Outputs registered next to the state
	always_ff @(posedge CLK or negedge RSTN) begin
		if (!RSTN) begin
			state        <= IDLE;
			run          <= 1'b0;
			clear        <= 1'b1;
			result_valid <= 1'b0;
		end else begin
			state        <= state_nxt;
			run          <= (state_nxt == FEED);
			clear        <= (state_nxt == IDLE);
			result_valid <= (state_nxt == DONE);
		end
	end

	a_valid_not_run: assert property (@(posedge CLK) disable iff (!RSTN)
		!(result_valid && run));

endmodule

//--- verilog/stair_geom_pkg.sv
package stair_geom_pkg;
	import mx_num_pkg::*;

	localparam int NUM_GROUPS = 4;
	localparam int GROUP_LEN  = 8;
	localparam int NUM_PAIRS  = NUM_GROUPS * (NUM_GROUPS - 1) / 2;
	localparam int FEED_LAST  = GROUP_LEN + NUM_GROUPS - 1; // Final count of a run
	localparam int CNT_W      = $clog2(FEED_LAST + 1);

	typedef logic [CNT_W-1:0] count_t;

	typedef elem_t [GROUP_LEN-1:0] group_t;
	typedef group_t [NUM_GROUPS-1:0] block_t;

	// Skewed operands entering the triangle
	typedef struct packed {
		elem_t [NUM_GROUPS-2:0] data;   // Rows 0 to N-2
		elem_t [NUM_GROUPS-1:1] weight; // Columns 1 to N-1
	} lanes_t;

	typedef elem_t [NUM_PAIRS-1:0] pair_results_t;

	// Slot of pair (r, c), rows in order and the highest column first
	function automatic int pair_idx(input int r, input int c);
		return r * (NUM_GROUPS - 1) - r * (r - 1) / 2 + (NUM_GROUPS - 1 - c);
	endfunction

endpackage

//--- verilog/stair_grid.sv
`timescale 1ns/1ps

module stair_grid
	import mx_num_pkg::*;
	import stair_geom_pkg::*;
(
	input  logic          CLK,
	input  logic          RSTN,
	input  logic          clear,
	input  op_e           operation,
	input  lanes_t        lanes,
	output pair_results_t results
);

	// Forwarded operands, indexed by the producing element
	wire elem_t d_fwd [NUM_GROUPS-1][NUM_GROUPS];
	wire elem_t w_fwd [NUM_GROUPS-1][NUM_GROUPS];
	wire elem_t acc [NUM_PAIRS];

	for (genvar r = 0; r < NUM_GROUPS - 1; r++) begin : g_row
		for (genvar c = r + 1; c < NUM_GROUPS; c++) begin : g_col
			wire elem_t d_src;
			wire elem_t w_src;

			// Data enters at the highest column
			if (c == NUM_GROUPS - 1) begin : g_d_edge
				assign d_src = lanes.data[r];
			end else begin : g_d_link
				assign d_src = d_fwd[r][c + 1];
			end

			// Weights enter at row 0
			if (r == 0) begin : g_w_edge
				assign w_src = lanes.weight[c];
			end else begin : g_w_link
				assign w_src = w_fwd[r - 1][c];
			end

			if (c == r + 1) begin : g_diag
				pair_pe u_pe (
					.CLK      (CLK),
					.RSTN     (RSTN),
					.clear    (clear),
					.operation(operation),
					.d_in     (d_src),
					.w_in     (w_src),
					.d_out    (),
					.w_out    (),
					.result   (acc[pair_idx(r, c)])
				);
			end else begin : g_body
				pair_pe u_pe (
					.CLK      (CLK),
					.RSTN     (RSTN),
					.clear    (clear),
					.operation(operation),
					.d_in     (d_src),
					.w_in     (w_src),
					.d_out    (d_fwd[r][c]),
					.w_out    (w_fwd[r][c]),
					.result   (acc[pair_idx(r, c)])
				);
			end
		end
	end

	always_comb begin
		for (int p = 0; p < NUM_PAIRS; p++) begin
			results[p] = acc[p];
		end
	end

endmodule

//--- verilog/stair_top.sv
`timescale 1ns/1ps

module stair_top
	import mx_num_pkg::*;
	import stair_geom_pkg::*;
(
	input  logic          CLK,
	input  logic          RSTN,
	input  logic          enable,
	input  op_e           operation,
	input  block_t        block,
	output pair_results_t results,
	output logic          result_valid
);

	logic   run;
	logic   clear;
	logic   last;
	count_t count;
	lanes_t lanes;

	run_fsm u_fsm (
		.CLK         (CLK),
		.RSTN        (RSTN),
		.enable      (enable),
		.last        (last),
		.run         (run),
		.clear       (clear),
		.result_valid(result_valid)
	);

	feed_counter u_cnt (
		.CLK  (CLK),
		.RSTN (RSTN),
		.run  (run),
		.count(count),
		.last (last)
	);

	operand_skewer u_skew (
		.CLK  (CLK),
		.RSTN (RSTN),
		.run  (run),
		.count(count),
		.block(block),
		.lanes(lanes)
	);

	stair_grid u_grid (
		.CLK      (CLK),
		.RSTN     (RSTN),
		.clear    (clear),
		.operation(operation),
		.lanes    (lanes),
		.results  (results)
	);

endmodule
